/* source/analog_pkg.sv */
/* widths, types, bus structs and register map of the analog core
   modules pull it in with a wildcard import in their header */
package analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////////////////////////////////////////

  localparam int SMP_W      = 14;  // converter sample width
  localparam int MUL_W      = 16;  // calibration gain width
  localparam int GAIN_SHIFT = 14;  // gain fraction bits
  localparam int CHN_NUM    = 2;   // analog channels
  localparam int PDM_CHN    = 4;   // pdm outputs
  localparam int PDM_W      = 8;   // pdm level width
  localparam int REGION_NUM = 8;   // bus regions, addr[22:20]
  localparam int REGION_LSB = 20;

  typedef logic signed [SMP_W-1:0]      sample_t;      // two's complement
  typedef logic        [SMP_W-1:0]      raw_sample_t;  // offset binary, neg slope
  typedef logic signed [MUL_W-1:0]      gain_t;
  typedef logic        [PDM_W-1:0]      pdm_lvl_t;
  typedef logic        [31:0]           bus_word_t;
  typedef logic        [2:0]            region_t;
  typedef logic        [REGION_LSB-1:0] reg_offs_t;    // offset inside a region

  typedef struct packed {
    gain_t   gain;
    sample_t offset;
  } cal_cfg_t;

  // master -> every region
  typedef struct packed {
    bus_word_t  addr;
    bus_word_t  wdata;
    logic [3:0] sel;    // byte select
  } sys_req_t;

  // region -> decoder
  typedef struct packed {
    bus_word_t rdata;
    logic      err;
    logic      ack;
  } sys_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map and reset values
  ////////////////////////////////////////////////////////////////////////////

  localparam bus_word_t REG_ID   = 32'h414e_0001;
  localparam gain_t     GAIN_ONE = gain_t'(1 << GAIN_SHIFT);  // unity gain
  localparam cal_cfg_t  CAL_RST  = '{gain: GAIN_ONE, offset: '0};  // identity

  // region 0, housekeeping
  localparam reg_offs_t HK_ID        = 'h00;  // read only
  localparam reg_offs_t HK_LED       = 'h04;
  localparam reg_offs_t HK_LOOP      = 'h08;
  localparam reg_offs_t HK_ADC_CAL_A = 'h10;  // cal words: gain [31:16], offset [13:0]
  localparam reg_offs_t HK_ADC_CAL_B = 'h14;
  localparam reg_offs_t HK_DAC_CAL_A = 'h18;
  localparam reg_offs_t HK_DAC_CAL_B = 'h1c;

  // region 1, pdm levels
  localparam reg_offs_t PDM_LVL_0 = 'h00;
  localparam reg_offs_t PDM_LVL_1 = 'h04;
  localparam reg_offs_t PDM_LVL_2 = 'h08;
  localparam reg_offs_t PDM_LVL_3 = 'h0c;

  // merge bus write data into an old word, lane by lane
  function automatic bus_word_t byte_merge(input bus_word_t old_w, input bus_word_t new_w,
                                           input logic [3:0] sel);
    bus_word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++)
    begin
      if (sel[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

endpackage

/* source/linear_cal.sv */
/* one-channel gain/offset calibration, two register stages
   out = sat(in * gain / 2^14 + offset) */
`timescale 1ns/1ps

module linear_cal
  import analog_pkg::*;
(
  input  logic     adc_clk,
  input  logic     top_rst,
  input  sample_t  dat_i,
  input  cal_cfg_t cfg_i,
  output sample_t  dat_o
);

  logic signed [SMP_W+MUL_W-1:0]          prod_q;  // full product, stage 1
  logic signed [SMP_W+MUL_W-GAIN_SHIFT-1:0] scaled;  // product / 2^14
  logic signed [SMP_W+MUL_W-GAIN_SHIFT:0]   sum;     // one guard bit for the offset
  logic [SMP_W+MUL_W-GAIN_SHIFT:SMP_W-1]  guard;   // must all match to fit
  sample_t                                sat;
  sample_t                                dat_q;

  // stage 1 product
  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      prod_q <= '0;
    else
      prod_q <= dat_i * cfg_i.gain;
  end

  assign scaled = prod_q[SMP_W+MUL_W-1:GAIN_SHIFT];  // arithmetic scale back
  assign sum    = scaled + cfg_i.offset;             // both signed, sign extended
  assign guard  = sum[SMP_W+MUL_W-GAIN_SHIFT:SMP_W-1];

  // clip to the 14-bit signed range
  always_comb
  begin
    if ((&guard) | ~(|guard))
      sat = sample_t'(sum[SMP_W-1:0]);
    else
      sat = {sum[SMP_W+MUL_W-GAIN_SHIFT], {(SMP_W-1){~sum[SMP_W+MUL_W-GAIN_SHIFT]}}};
  end

  // stage 2 result
  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      dat_q <= '0;
    else
      dat_q <= sat;
  end

  assign dat_o = dat_q;

endmodule

/* source/sys_bus_decoder.sv */
/* splits the system bus into eight regions by addr[22:20], fans the strobes
   out to the two live regions and answers the six empty ones itself */
`timescale 1ns/1ps

module sys_bus_decoder
  import analog_pkg::*;
(
  input  logic     adc_clk,
  input  logic     top_rst,
  input  logic     sys_wen_i,
  input  logic     sys_ren_i,
  input  region_t  region_i,    // address field of the request
  output logic [1:0] wen_o,     // [0] housekeeping, [1] pdm
  output logic [1:0] ren_o,
  input  sys_rsp_t rsp_hk_i,
  input  sys_rsp_t rsp_pdm_i,
  output sys_rsp_t sys_rsp_o
);

  logic [REGION_NUM-1:0] region_oh;  // one-hot region select
  logic                  strobe;
  region_t               region_q;   // region of the pending access
  logic                  empty_ack;  // ack for regions 2..7

  assign region_oh = {{(REGION_NUM-1){1'b0}}, 1'b1} << region_i;
  assign strobe    = sys_wen_i | sys_ren_i;

  // only the addressed live region sees the strobe
  assign wen_o = region_oh[1:0] & {2{sys_wen_i}};
  assign ren_o = region_oh[1:0] & {2{sys_ren_i}};

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      region_q  <= '0;
      empty_ack <= 1'b0;
    end
    else
    begin
      if (strobe)
        region_q <= region_i;  // pairs the response with its request
      empty_ack <= strobe & (|region_oh[REGION_NUM-1:2]);
    end
  end

  // response mux, keyed by the remembered region
  always_comb
  begin
    case (region_q)
      region_t'(0): sys_rsp_o = rsp_hk_i;
      region_t'(1): sys_rsp_o = rsp_pdm_i;
      default:      sys_rsp_o = '{rdata: '0, err: 1'b0, ack: empty_ack};  // empty
    endcase
  end

endmodule

/* source/housekeeping_regs.sv */
/* region 0 register file: ID word, LEDs, digital loopback and the gain/offset
   calibration of both ADC and both DAC channels */
`timescale 1ns/1ps

module housekeeping_regs
  import analog_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    top_rst,
  input  sys_req_t                sys_req_i,
  input  logic                    wen_i,
  input  logic                    ren_i,
  output sys_rsp_t                sys_rsp_o,
  output logic [7:0]              led_o,
  output logic                    digital_loop_o,
  output cal_cfg_t [CHN_NUM-1:0]  adc_cal_o,
  output cal_cfg_t [CHN_NUM-1:0]  dac_cal_o
);

  reg_offs_t              offs;
  logic                   hit;        // offset is mapped
  bus_word_t              rd_word;    // current value at offs
  bus_word_t              wr_word;    // rd_word with write lanes merged in
  logic [7:0]             led_q;
  logic                   loop_q;
  cal_cfg_t [CHN_NUM-1:0] adc_cal_q;
  cal_cfg_t [CHN_NUM-1:0] dac_cal_q;
  logic                   rsp_ack;
  logic                   rsp_err;
  bus_word_t              rsp_rdata;

  // calibration word layout, gain [31:16] and offset [13:0]
  function automatic bus_word_t cal_pack(input cal_cfg_t c);
    return {c.gain, 2'b00, c.offset};
  endfunction

  function automatic cal_cfg_t cal_unpack(input bus_word_t w);
    return '{gain: gain_t'(w[31:16]), offset: sample_t'(w[SMP_W-1:0])};
  endfunction

  assign offs = sys_req_i.addr[REGION_LSB-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // read view and write merge
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    hit = 1'b1;
    case (offs)
      HK_ID:        rd_word = REG_ID;
      HK_LED:       rd_word = bus_word_t'(led_q);
      HK_LOOP:      rd_word = bus_word_t'(loop_q);
      HK_ADC_CAL_A: rd_word = cal_pack(adc_cal_q[0]);
      HK_ADC_CAL_B: rd_word = cal_pack(adc_cal_q[1]);
      HK_DAC_CAL_A: rd_word = cal_pack(dac_cal_q[0]);
      HK_DAC_CAL_B: rd_word = cal_pack(dac_cal_q[1]);
      default:
      begin
        rd_word = '0;  // unmapped reads as zero
        hit     = 1'b0;
      end
    endcase
  end

  assign wr_word = byte_merge(rd_word, sys_req_i.wdata, sys_req_i.sel);

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      led_q     <= '0;
      loop_q    <= 1'b0;
      adc_cal_q <= {CHN_NUM{CAL_RST}};
      dac_cal_q <= {CHN_NUM{CAL_RST}};
    end
    else if (wen_i)
    begin
      case (offs)  // HK_ID and unmapped offsets drop the write
        HK_LED:       led_q        <= wr_word[7:0];
        HK_LOOP:      loop_q       <= wr_word[0];
        HK_ADC_CAL_A: adc_cal_q[0] <= cal_unpack(wr_word);
        HK_ADC_CAL_B: adc_cal_q[1] <= cal_unpack(wr_word);
        HK_DAC_CAL_A: dac_cal_q[0] <= cal_unpack(wr_word);
        HK_DAC_CAL_B: dac_cal_q[1] <= cal_unpack(wr_word);
        default:      ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus response, one cycle after the strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      rsp_ack <= 1'b0;
      rsp_err <= 1'b0;
    end
    else
    begin
      rsp_ack <= wen_i | ren_i;
      rsp_err <= (wen_i | ren_i) & ~hit;
    end
  end

  always_ff @(posedge adc_clk)
    rsp_rdata <= ren_i ? rd_word : '0;

  assign sys_rsp_o      = '{rdata: rsp_rdata, err: rsp_err, ack: rsp_ack};
  assign led_o          = led_q;
  assign digital_loop_o = loop_q;
  assign adc_cal_o      = adc_cal_q;
  assign dac_cal_o      = dac_cal_q;

endmodule

/* source/analog_frontend.sv */
/* ADC capture and format conversion, digital loopback mux, DAC calibration
   and format conversion; the generator samples enter in two's complement */
`timescale 1ns/1ps

module analog_frontend
  import analog_pkg::*;
(
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  raw_sample_t [CHN_NUM-1:0] adc_raw_i,
  input  sample_t     [CHN_NUM-1:0] gen_dat_i,
  input  logic                      digital_loop_i,
  input  cal_cfg_t    [CHN_NUM-1:0] adc_cal_i,
  input  cal_cfg_t    [CHN_NUM-1:0] dac_cal_i,
  output sample_t     [CHN_NUM-1:0] adc_dat_o,
  output raw_sample_t [CHN_NUM-1:0] dac_raw_o
);

  sample_t [CHN_NUM-1:0] adc_cap_q;  // converted capture
  sample_t [CHN_NUM-1:0] adc_mux;    // calibration input
  sample_t [CHN_NUM-1:0] dac_cal;    // calibrated generator data

  // offset binary with negative slope <-> two's complement, same both ways
  function automatic logic [SMP_W-1:0] slope_flip(input logic [SMP_W-1:0] x);
    return {x[SMP_W-1], ~x[SMP_W-2:0]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      adc_cap_q <= '0;
    else
      for (int ch = 0; ch < CHN_NUM; ch++)
        adc_cap_q[ch] <= sample_t'(slope_flip(adc_raw_i[ch]));
  end

  assign adc_mux = digital_loop_i ? dac_cal : adc_cap_q;  // loopback skips the pins

  ////////////////////////////////////////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      dac_raw_o <= '0;
    else
      for (int ch = 0; ch < CHN_NUM; ch++)
        dac_raw_o[ch] <= raw_sample_t'(slope_flip(dac_cal[ch]));  // output register
  end

  // calibration per channel, adc and dac
  for (genvar ch = 0; ch < CHN_NUM; ch++)
  begin : g_chn
    linear_cal i_adc_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (adc_mux[ch]),
      .cfg_i   (adc_cal_i[ch]),
      .dat_o   (adc_dat_o[ch])
    );

    linear_cal i_dac_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (gen_dat_i[ch]),
      .cfg_i   (dac_cal_i[ch]),
      .dat_o   (dac_cal[ch])
    );
  end

endmodule

/* source/pdm_outputs.sv */
/* region 1: four bus-writable PDM levels, each driving a first-order
   pulse-density modulator whose output is the accumulator carry */
`timescale 1ns/1ps

module pdm_outputs
  import analog_pkg::*;
(
  input  logic               adc_clk,
  input  logic               top_rst,
  input  sys_req_t           sys_req_i,
  input  logic               wen_i,
  input  logic               ren_i,
  output sys_rsp_t           sys_rsp_o,
  output logic [PDM_CHN-1:0] dac_pwm_o
);

  reg_offs_t                    offs;
  logic                         hit;
  logic [$clog2(PDM_CHN)-1:0]   idx;      // addressed level
  bus_word_t                    rd_word;
  bus_word_t                    wr_word;
  pdm_lvl_t [PDM_CHN-1:0]       lvl_q;
  pdm_lvl_t [PDM_CHN-1:0]       acc_q;    // modulator accumulators
  logic     [PDM_CHN-1:0]       pwm_q;
  logic                         rsp_ack;
  logic                         rsp_err;
  bus_word_t                    rsp_rdata;

  assign offs = sys_req_i.addr[REGION_LSB-1:0];

  always_comb
  begin
    hit = 1'b1;
    idx = '0;
    case (offs)
      PDM_LVL_0: idx = 2'd0;
      PDM_LVL_1: idx = 2'd1;
      PDM_LVL_2: idx = 2'd2;
      PDM_LVL_3: idx = 2'd3;
      default:   hit = 1'b0;
    endcase
    rd_word = hit ? bus_word_t'(lvl_q[idx]) : '0;
  end

  assign wr_word = byte_merge(rd_word, sys_req_i.wdata, sys_req_i.sel);

  ////////////////////////////////////////////////////////////////////////////
  // levels and bus response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      lvl_q   <= '0;
      rsp_ack <= 1'b0;
      rsp_err <= 1'b0;
    end
    else
    begin
      if (wen_i & hit)
        lvl_q[idx] <= wr_word[PDM_W-1:0];
      rsp_ack <= wen_i | ren_i;
      rsp_err <= (wen_i | ren_i) & ~hit;  // unmapped offset
    end
  end

  always_ff @(posedge adc_clk)
    rsp_rdata <= ren_i ? rd_word : '0;

  assign sys_rsp_o = '{rdata: rsp_rdata, err: rsp_err, ack: rsp_ack};

  ////////////////////////////////////////////////////////////////////////////
  // modulators
  ////////////////////////////////////////////////////////////////////////////

  // carry out of acc + level, high level times per 256 cycles
  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      acc_q <= '0;
      pwm_q <= '0;
    end
    else
      for (int ch = 0; ch < PDM_CHN; ch++)
        {pwm_q[ch], acc_q[ch]} <= {1'b0, acc_q[ch]} + {1'b0, lvl_q[ch]};
  end

  assign dac_pwm_o = pwm_q;

endmodule

/* source/analog_top.sv */
/* analog core top: bus decoder, housekeeping, ADC/DAC frontend and PDM
   outputs, all on adc_clk with top_rst */
`timescale 1ns/1ps

module analog_top
  import analog_pkg::*;
(
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // system bus
  input  sys_req_t                  sys_req_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output sys_rsp_t                  sys_rsp_o,
  // converters
  input  raw_sample_t [CHN_NUM-1:0] adc_raw_i,
  input  sample_t     [CHN_NUM-1:0] gen_dat_i,   // generator samples
  output sample_t     [CHN_NUM-1:0] adc_dat_o,
  output raw_sample_t [CHN_NUM-1:0] dac_raw_o,
  output logic        [PDM_CHN-1:0] dac_pwm_o,
  output logic        [7:0]         led_o
);

  region_t                region;
  logic [1:0]             wen;           // [0] hk, [1] pdm
  logic [1:0]             ren;
  sys_rsp_t               rsp_hk;
  sys_rsp_t               rsp_pdm;
  logic                   digital_loop;
  cal_cfg_t [CHN_NUM-1:0] adc_cal;
  cal_cfg_t [CHN_NUM-1:0] dac_cal;

  assign region = sys_req_i.addr[REGION_LSB +: $bits(region_t)];

  sys_bus_decoder i_dec (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sys_wen_i (sys_wen_i),
    .sys_ren_i (sys_ren_i),
    .region_i  (region),
    .wen_o     (wen),
    .ren_o     (ren),
    .rsp_hk_i  (rsp_hk),
    .rsp_pdm_i (rsp_pdm),
    .sys_rsp_o (sys_rsp_o)
  );

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .sys_req_i      (sys_req_i),
    .wen_i          (wen[0]),
    .ren_i          (ren[0]),
    .sys_rsp_o      (rsp_hk),
    .led_o          (led_o),
    .digital_loop_o (digital_loop),
    .adc_cal_o      (adc_cal),
    .dac_cal_o      (dac_cal)
  );

  analog_frontend i_afe (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_raw_i      (adc_raw_i),
    .gen_dat_i      (gen_dat_i),
    .digital_loop_i (digital_loop),
    .adc_cal_i      (adc_cal),
    .dac_cal_i      (dac_cal),
    .adc_dat_o      (adc_dat_o),
    .dac_raw_o      (dac_raw_o)
  );

  pdm_outputs i_pdm (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sys_req_i (sys_req_i),
    .wen_i     (wen[1]),
    .ren_i     (ren[1]),
    .sys_rsp_o (rsp_pdm),
    .dac_pwm_o (dac_pwm_o)
  );

endmodule

/* sim/analog_tb.sv */
/* table-driven testbench for the analog core that covers bus decode and the register map
   along with the ADC/DAC calibration paths, digital loopback and PDM density */
`timescale 1ns/1ps

module analog_tb
  import analog_pkg::*;
();

  localparam int        STREAM_LEN = 16;  // samples per calibration case
  localparam int        BUS_NUM    = 16;
  localparam int        CAL_NUM    = 6;
  localparam int        PDM_NUM    = 3;
  localparam int        TEST_NUM   = BUS_NUM + CAL_NUM + PDM_NUM;
  localparam bus_word_t PDM_BASE   = 32'h0010_0000;  // region 1
  localparam bus_word_t CAL_RESET  = {GAIN_ONE, 16'h0000};  // unity gain and zero offset
  localparam longint    SMP_MAX    = 2**(SMP_W-1) - 1;
  localparam longint    SMP_MIN    = -(2**(SMP_W-1));

  typedef struct {
    string     name;
    logic      wr;     // high for a write
    bus_word_t addr;
    bus_word_t wdata;
    bus_word_t rdata;  // expected read data
    logic      err;    // expected
  } bus_op_t;

  typedef struct {
    string   name;
    gain_t   adc_gain;
    sample_t adc_off;
    gain_t   dac_gain;
    sample_t dac_off;
    logic    loop;
  } cal_case_t;

  typedef struct {
    string    name;
    pdm_lvl_t lvl [PDM_CHN];
  } pdm_case_t;

  logic                      adc_clk;
  logic                      top_rst;
  sys_req_t                  sys_req_i;
  logic                      sys_wen_i;
  logic                      sys_ren_i;
  sys_rsp_t                  sys_rsp_o;
  raw_sample_t [CHN_NUM-1:0] adc_raw_i;
  sample_t     [CHN_NUM-1:0] gen_dat_i;
  sample_t     [CHN_NUM-1:0] adc_dat_o;
  raw_sample_t [CHN_NUM-1:0] dac_raw_o;
  logic        [PDM_CHN-1:0] dac_pwm_o;
  logic        [7:0]         led_o;

  int seed = 32'h3b90_7486;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and expected values
  ////////////////////////////////////////////////////////////////////////////

  bus_op_t bus_tab [BUS_NUM] = '{
    '{"id read",          1'b0, 32'h0000_0000, 32'h0,         REG_ID,        1'b0},
    '{"adc cal a reset",  1'b0, 32'h0000_0010, 32'h0,         CAL_RESET,     1'b0},
    '{"dac cal b reset",  1'b0, 32'h0000_001c, 32'h0,         CAL_RESET,     1'b0},
    '{"loop reset",       1'b0, 32'h0000_0008, 32'h0,         32'h0,         1'b0},
    '{"led write",        1'b1, 32'h0000_0004, 32'h0000_005a, 32'h0,         1'b0},
    '{"led read",         1'b0, 32'h0000_0004, 32'h0,         32'h0000_005a, 1'b0},
    '{"id write",         1'b1, 32'h0000_0000, 32'hffff_ffff, 32'h0,         1'b0},
    '{"id keeps value",   1'b0, 32'h0000_0000, 32'h0,         REG_ID,        1'b0},
    '{"hk hole read",     1'b0, 32'h0000_000c, 32'h0,         32'h0,         1'b1},
    '{"hk hole write",    1'b1, 32'h0000_0040, 32'h0000_1234, 32'h0,         1'b1},
    '{"pdm lvl 2 write",  1'b1, 32'h0010_0008, 32'h0000_0077, 32'h0,         1'b0},
    '{"pdm lvl 2 read",   1'b0, 32'h0010_0008, 32'h0,         32'h0000_0077, 1'b0},
    '{"pdm hole read",    1'b0, 32'h0010_0010, 32'h0,         32'h0,         1'b1},
    '{"region 2 read",    1'b0, 32'h0020_0000, 32'h0,         32'h0,         1'b0},
    '{"region 5 write",   1'b1, 32'h0050_0004, 32'hdead_beef, 32'h0,         1'b0},
    '{"region 7 read",    1'b0, 32'h0070_0abc, 32'h0,         32'h0,         1'b0}
  };

  // gains are 2.14 fixed point
  cal_case_t cal_tab [CAL_NUM] = '{
    '{"identity",        GAIN_ONE, 14'h0000, GAIN_ONE, 14'h0000, 1'b0},
    '{"gain and offset", 16'h2000, 14'h0123, 16'h6000, 14'h3ed4, 1'b0},
    '{"saturation",      16'h7000, 14'h1000, 16'h7fff, 14'h0fff, 1'b0},
    '{"negative gain",   16'hc000, 14'h2000, 16'ha000, 14'h0000, 1'b0},
    '{"loop identity",   GAIN_ONE, 14'h0000, GAIN_ONE, 14'h0000, 1'b1},
    '{"loop with cal",   16'h5000, 14'h3f00, 16'h3000, 14'h0200, 1'b1}
  };

  pdm_case_t pdm_tab [PDM_NUM] = '{
    '{"pdm set a", '{8'h00, 8'h01, 8'h80, 8'hff}},
    '{"pdm set b", '{8'h3c, 8'hc3, 8'h7f, 8'h55}},
    '{"pdm set c", '{8'hfe, 8'h02, 8'h00, 8'hab}}
  };

  analog_top dut (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sys_req_i (sys_req_i),
    .sys_wen_i (sys_wen_i),
    .sys_ren_i (sys_ren_i),
    .sys_rsp_o (sys_rsp_o),
    .adc_raw_i (adc_raw_i),
    .gen_dat_i (gen_dat_i),
    .adc_dat_o (adc_dat_o),
    .dac_raw_o (dac_raw_o),
    .dac_pwm_o (dac_pwm_o),
    .led_o     (led_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // offset binary with negative slope keeps the top bit and inverts the rest
  function automatic sample_t from_raw(input raw_sample_t r);
    return sample_t'({r[SMP_W-1], ~r[SMP_W-2:0]});
  endfunction

  function automatic raw_sample_t to_raw(input sample_t s);
    return raw_sample_t'({s[SMP_W-1], ~s[SMP_W-2:0]});
  endfunction

  // floor of s * gain / 2^14 plus offset then clipped to 14 bits
  function automatic sample_t calibrate(input sample_t s, input cal_cfg_t cfg);
    gain_t   g;
    sample_t o;
    longint  prod;
    longint  v;
    g    = cfg.gain;
    o    = cfg.offset;
    prod = longint'(s) * longint'(g);
    v    = (prod >>> 14) + longint'(o);
    if (v > SMP_MAX)
      v = SMP_MAX;
    else if (v < SMP_MIN)
      v = SMP_MIN;
    return sample_t'(v);
  endfunction

  function automatic bus_word_t cal_word(input cal_cfg_t cfg);
    return {cfg.gain, 2'b00, cfg.offset};  // gain in [31:16] and offset in [13:0]
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checking and bus access
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input bus_word_t exp, input bus_word_t act);
    if (exp !== act)
    begin
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // one strobe then a wait for the ack that counts its latency
  task automatic bus_access(input string name, input logic wr, input bus_word_t addr,
                            input bus_word_t wdata, output sys_rsp_t rsp);
    int waited;
    @(posedge adc_clk);
    sys_req_i <= '{addr: addr, wdata: wdata, sel: 4'hf};
    sys_wen_i <= wr;
    sys_ren_i <= ~wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;  // single-cycle strobe
    sys_ren_i <= 1'b0;
    waited = 1;
    @(negedge adc_clk);
    while (!sys_rsp_o.ack && waited < 8)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_rsp_o.ack)
    begin
      $display("bus access %s got no ack within 8 cycles", name);
      $display("Simulation failed");
      $fatal(1, "bus ack timeout");
    end
    else
    begin
      check({name, " ack latency"}, 32'd1, bus_word_t'(waited));
      rsp = sys_rsp_o;
    end
  endtask

  task automatic write_reg(input string name, input bus_word_t addr, input bus_word_t wdata);
    sys_rsp_t rsp;
    bus_access(name, 1'b1, addr, wdata, rsp);
    check({name, " err"}, 32'd0, bus_word_t'(rsp.err));
  endtask

  task automatic read_reg(input string name, input bus_word_t addr, input bus_word_t exp_data);
    sys_rsp_t rsp;
    bus_access(name, 1'b0, addr, 32'h0, rsp);
    check({name, " err"}, 32'd0, bus_word_t'(rsp.err));
    check({name, " rdata"}, exp_data, rsp.rdata);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sample paths and pdm
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_cal(input cal_case_t c);
    raw_sample_t raw_h [STREAM_LEN][CHN_NUM];
    sample_t     gen_h [STREAM_LEN][CHN_NUM];
    cal_cfg_t    acfg  [CHN_NUM];
    cal_cfg_t    dcfg  [CHN_NUM];
    sample_t     exp_s;
    int          lat;
    acfg[0] = '{gain: c.adc_gain, offset: c.adc_off};
    acfg[1] = '{gain: c.adc_gain, offset: -c.adc_off};  // channel b mirrored offset
    dcfg[0] = '{gain: c.dac_gain, offset: c.dac_off};
    dcfg[1] = '{gain: c.dac_gain, offset: -c.dac_off};
    write_reg({c.name, " adc cal a"}, bus_word_t'(HK_ADC_CAL_A), cal_word(acfg[0]));
    write_reg({c.name, " adc cal b"}, bus_word_t'(HK_ADC_CAL_B), cal_word(acfg[1]));
    write_reg({c.name, " dac cal a"}, bus_word_t'(HK_DAC_CAL_A), cal_word(dcfg[0]));
    write_reg({c.name, " dac cal b"}, bus_word_t'(HK_DAC_CAL_B), cal_word(dcfg[1]));
    write_reg({c.name, " loop"}, bus_word_t'(HK_LOOP), bus_word_t'(c.loop));
    lat = c.loop ? 4 : 3;  // loopback goes through both calibrations
    for (int i = 0; i < STREAM_LEN + 4; i++)
    begin
      @(posedge adc_clk);
      if (i < STREAM_LEN)
      begin
        for (int ch = 0; ch < CHN_NUM; ch++)
        begin
          raw_h[i][ch] = raw_sample_t'($random(seed));
          gen_h[i][ch] = sample_t'($random(seed));
          adc_raw_i[ch] <= raw_h[i][ch];
          gen_dat_i[ch] <= gen_h[i][ch];
        end
      end
      @(negedge adc_clk);  // outputs settled
      for (int ch = 0; ch < CHN_NUM; ch++)
      begin
        if (i >= 3 && i < STREAM_LEN + 3)
        begin
          exp_s = calibrate(gen_h[i-3][ch], dcfg[ch]);
          check($sformatf("%s dac ch%0d smp%0d", c.name, ch, i-3),
                bus_word_t'(to_raw(exp_s)), bus_word_t'(dac_raw_o[ch]));
        end
        if (i >= lat && i < STREAM_LEN + lat)
        begin
          if (c.loop)
            exp_s = calibrate(calibrate(gen_h[i-lat][ch], dcfg[ch]), acfg[ch]);
          else
            exp_s = calibrate(from_raw(raw_h[i-lat][ch]), acfg[ch]);
          check($sformatf("%s adc ch%0d smp%0d", c.name, ch, i-lat),
                bus_word_t'(exp_s), bus_word_t'(adc_dat_o[ch]));
        end
      end
    end
  endtask

  // high count over 256 cycles must equal the level
  task automatic run_pdm(input pdm_case_t p);
    int cnt [PDM_CHN];
    for (int ch = 0; ch < PDM_CHN; ch++)
      write_reg($sformatf("%s lvl%0d", p.name, ch), PDM_BASE + bus_word_t'(4 * ch),
                bus_word_t'(p.lvl[ch]));
    repeat (2) @(posedge adc_clk);  // last level is in the modulator
    for (int ch = 0; ch < PDM_CHN; ch++)
      cnt[ch] = 0;
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int ch = 0; ch < PDM_CHN; ch++)
        cnt[ch] += int'(dac_pwm_o[ch]);
    end
    for (int ch = 0; ch < PDM_CHN; ch++)
      check($sformatf("%s density ch%0d", p.name, ch), bus_word_t'(p.lvl[ch]),
            bus_word_t'(cnt[ch]));
    for (int ch = 0; ch < PDM_CHN; ch++)
      read_reg($sformatf("%s lvl%0d read", p.name, ch), PDM_BASE + bus_word_t'(4 * ch),
               bus_word_t'(p.lvl[ch]));
  endtask

  initial
  begin
    sys_rsp_t rsp;
    sys_req_i = '0;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    adc_raw_i = '0;
    gen_dat_i = '0;
    top_rst   = 1'b1;
    repeat (3) @(posedge adc_clk);
    top_rst <= 1'b0;
    @(negedge adc_clk);
    check("reset led_o", 32'd0, bus_word_t'(led_o));
    check("reset dac_pwm_o", 32'd0, bus_word_t'(dac_pwm_o));

    for (int i = 0; i < BUS_NUM; i++)
    begin
      bus_access(bus_tab[i].name, bus_tab[i].wr, bus_tab[i].addr, bus_tab[i].wdata, rsp);
      if (!bus_tab[i].wr)
        check({bus_tab[i].name, " rdata"}, bus_tab[i].rdata, rsp.rdata);
      check({bus_tab[i].name, " err"}, bus_word_t'(bus_tab[i].err), bus_word_t'(rsp.err));
    end
    check("led_o follows", 32'h0000_005a, bus_word_t'(led_o));

    for (int i = 0; i < CAL_NUM; i++)
      run_cal(cal_tab[i]);
    for (int i = 0; i < PDM_NUM; i++)
      run_pdm(pdm_tab[i]);

    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog allows 300 cycles per table entry
  initial
  begin
    repeat (TEST_NUM * 300) @(posedge adc_clk);
    $display("watchdog expired after %0d cycles and the tests did not finish", TEST_NUM * 300);
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

/* files.f */
source/analog_pkg.sv
source/linear_cal.sv
source/sys_bus_decoder.sv
source/housekeeping_regs.sv
source/analog_frontend.sv
source/pdm_outputs.sv
source/analog_top.sv
sim/analog_tb.sv

/* Bender.yml */
package:
  name: analog_core

sources:
  - files:
      - source/analog_pkg.sv
      - source/linear_cal.sv
      - source/sys_bus_decoder.sv
      - source/housekeeping_regs.sv
      - source/analog_frontend.sv
      - source/pdm_outputs.sv
      - source/analog_top.sv
  - target: simulation
    files:
      - sim/analog_tb.sv
